// ==== playback_input.txt ====
# test_id  base_addr(hex)  block_count  max_latency  underrun_expected
# Latency in clocks, a frame lasts 128 clocks.
1 00000000 1 4 0
2 00012340 3 12 0
3 1fffff00 2 100 0
4 00000400 2 300 1
5 00bee000 1 1 0

// ==== flist.f ====
mem_fetch_pkg.sv
audio_fmt_pkg.sv
playback_sequencer.sv
sample_fetcher.sv
frame_unpacker.sv
i2s_transmitter.sv
audio_playback_top.sv
tb_audio_playback.sv

// ==== tb_audio_playback.sv ====
// Testbench for audio playback. Memory answers in order after 1 to N cycles, and frames follow the address rule.
`timescale 1ns/1ps
`default_nettype none

module tb_audio_playback;
	import mem_fetch_pkg::*;
	import audio_fmt_pkg::*;

	logic         clock;
	logic         reset_l;
	logic         start;
	mem_addr_t    start_base;
	block_count_t block_count;
	logic         busy;
	logic         done;
	logic         underrun;
	mem_addr_t    mem_addr;
	logic         mem_read_en;
	mem_word_t    mem_data;
	logic         mem_ack;
	logic         bclk;
	logic         lrclk;
	logic         sdata;

	mem_addr_t    test_base;	// Base of the running test.
	mem_addr_t    expect_addr;	// Next read address due.
	int           max_lat = 1;	// Longest memory latency, in clocks.
	int           total;		// Frames due in the running test.
	int           rx_idx;		// Rule index of the next frame due.
	int           rx_frames;
	int           rx_cnt;		// Bits still missing from the frame on the line.
	logic [31:0]  rx_shift;
	logic         lr_prev;
	logic         skip_ok;		// Underrun test, frames may be missing.
	logic         busy_last;
	int           done_count;
	logic         underrun_seen;
	int           err_count;
	int           test_count;
	int           cur_id;		// Id of the running test.

	audio_playback_top DUT (.clock, .reset_l, .start, .start_base, .block_count, .busy,
		.done, .underrun, .mem_addr, .mem_read_en, .mem_data, .mem_ack, .bclk, .lrclk,
		.sdata);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// 20 ns period.
	end

	//////////////////////////////////////////////////////////////////////
	// Reference rule and checks.
	//////////////////////////////////////////////////////////////////////

	// Lane k holds the low address bits XOR k * 1111h.
	function automatic mem_word_t word_rule(input mem_addr_t addr);
		mem_word_t w;
		for (int k = 0; k < 4; k++)
			w[16 * k +: 16] = addr[15:0] ^ (16'(k) * 16'h1111);
		return w;
	endfunction

	// Frame n is half n % 2 of word n / 2, left in the upper lane.
	function automatic stereo_frame_t expected_frame(input int n);
		mem_word_t     w;
		stereo_frame_t f;
		w       = word_rule(test_base + mem_addr_t'(n / 2));
		f.left  = w[32 * (n % 2) + 16 +: 16];
		f.right = w[32 * (n % 2) +: 16];
		return f;
	endfunction

	task automatic check_frame(input stereo_frame_t got, input stereo_frame_t exp,
			input string what);
		if (got !== exp) begin
			err_count++;
			$display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
		if (got !== exp) begin
			err_count++;
			$display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			err_count++;
			$display("error at %0d ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s, at %0d ns in test %0d", why, $time, cur_id);
		$display("sim failed");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory model and monitors.
	//////////////////////////////////////////////////////////////////////

	initial begin : memory_model
		mem_addr_t rd_addr;
		int        lat;
		void'($urandom(32'h7408_420c));
		forever begin
			@(negedge clock);
			mem_ack = 1'b0;					// Ack lasts one cycle.
			check_flag(mem_read_en & DUT.u_fetch.chunk_valid, 1'b0, "read while chunk waits");
			if (mem_read_en) begin
				rd_addr = mem_addr;
				check_addr(rd_addr, expect_addr, "read address");
				expect_addr = expect_addr + 1'b1;
				lat = 1 + int'($urandom % 32'(max_lat));
				repeat (lat) begin
					@(negedge clock);
					check_flag(mem_read_en, 1'b0, "read before acknowledge");
				end
				mem_data = word_rule(rd_addr);
				mem_ack  = 1'b1;
			end
		end
	end

	// Counts done, and underrun is allowed only while busy or one cycle after.
	always @(negedge clock) begin
		if (done)
			done_count++;
		if (underrun) begin
			underrun_seen = 1'b1;
			check_flag(busy | busy_last, 1'b1, "busy at underrun");
		end
		busy_last = busy;
	end

	task automatic take_frame(input stereo_frame_t got);
		if (skip_ok)
			while (rx_idx < total && expected_frame(rx_idx) != got)
				rx_idx++;				// Gaps allowed, repeats are not.
		check_frame(got, expected_frame(rx_idx), "received frame");
		rx_idx++;
		rx_frames++;
	endtask

	// MSB comes one bit clock after the lrclk fall.
	initial begin : i2s_receiver
		lr_prev = 1'b1;
		rx_cnt  = 0;
		forever begin
			@(posedge bclk);
			if (rx_cnt > 0) begin
				if (rx_cnt > 1)
					check_flag(lrclk, logic'(rx_cnt <= FRAME_BITS / 2 + 1), "word select");
				rx_shift = {rx_shift[30:0], sdata};
				rx_cnt--;
				if (rx_cnt == 0)
					take_frame(stereo_frame_t'(rx_shift));
			end
			if (lr_prev && !lrclk)
				rx_cnt = FRAME_BITS;			// New frame starts next slot.
			lr_prev = lrclk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence.
	//////////////////////////////////////////////////////////////////////

	task automatic run_test(input int id, input mem_addr_t base, input int blocks,
			input int lat, input logic exp_ur);
		int cycles;
		int errs_before;
		int limit;
		errs_before   = err_count;
		test_count++;
		cur_id        = id;
		test_base     = base;
		expect_addr   = base;
		max_lat       = lat;
		total         = blocks * WORDS_PER_BLOCK * 2;
		rx_idx        = 0;
		rx_frames     = 0;
		skip_ok       = exp_ur;
		done_count    = 0;
		underrun_seen = 1'b0;
		limit         = blocks * WORDS_PER_BLOCK * (lat + 300) + 1000;
		@(negedge clock);
		start       = 1'b1;
		start_base  = base;
		block_count = block_count_t'(blocks);
		@(negedge clock);
		start = 1'b0;
		check_flag(busy, 1'b1, "busy after start");
		@(negedge clock);
		start       = 1'b1;				// Second start, ignored while busy.
		start_base  = base ^ 29'h0155_5555;
		block_count = 8'd5;
		@(negedge clock);
		start  = 1'b0;
		cycles = 0;
		while (!done) begin
			@(negedge clock);
			cycles++;
			if (cycles > limit)
				abort_run("timeout waiting for done");
		end
		check_flag(busy, 1'b0, "busy with done");
		check_addr(expect_addr, base + mem_addr_t'(blocks * WORDS_PER_BLOCK), "end address");
		cycles = 0;
		while (rx_idx < total) begin
			@(negedge clock);
			cycles++;
			if (cycles > 2000)
				abort_run("timeout waiting for the last frame");
		end
		repeat (200) @(negedge clock);			// Room for a stray done.
		check_flag(done_count == 1, 1'b1, "single done pulse");
		check_flag(rx_cnt != 0, 1'b0, "last frame incomplete");
		check_flag(underrun_seen, exp_ur, "underrun seen");
		if (!exp_ur)
			check_flag(rx_frames == total, 1'b1, "frame count");
		$display("test %0d: base %h, %0d blocks, latency up to %0d, %0d frames, %0d errors",
			id, base, blocks, lat, rx_frames, err_count - errs_before);
	endtask

	initial begin : main
		int               fd;
		int               id;
		int               blocks;
		int               lat_in;
		int               exp_ur;
		mem_addr_t        base_in;
		logic [8*120-1:0] line;
		reset_l     = 1'b0;
		start       = 1'b0;
		start_base  = '0;
		block_count = '0;
		mem_data    = '0;
		mem_ack     = 1'b0;
		err_count   = 0;
		test_count  = 1;
		cur_id      = 0;
		busy_last   = 1'b0;
		repeat (16) @(negedge clock);
		reset_l = 1'b1;
		repeat (100) begin				// Quiet line before any start.
			@(negedge clock);
			check_flag(mem_read_en | busy | done | underrun | sdata | ~lrclk, 1'b0,
				"activity before start");
		end
		$display("test 0: reset and idle, %0d errors", err_count);
		fd = $fopen("playback_input.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open playback_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				if ($fgets(line, fd) != 0)
					if ($sscanf(line, "%d %h %d %d %d", id, base_in, blocks, lat_in,
							exp_ur) == 5)
						run_test(id, base_in, blocks, lat_in, exp_ur[0]);
			end
			$fclose(fd);
			$display("tests %0d, errors %0d", test_count, err_count);
			if (err_count == 0)
				$display("sim passed");
			else
				$display("sim failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== audio_playback_top.sv ====
// Playback top. The bit clock comes from the system clock, and the DRAM port needs a real controller.
`timescale 1ns/1ps
`default_nettype none

module audio_playback_top (
	input  logic                        clock,
	input  logic                        reset_l,
	input  logic                        start,
	input  mem_fetch_pkg::mem_addr_t    start_base,
	input  mem_fetch_pkg::block_count_t block_count,
	output logic                        busy,
	output logic                        done,
	output logic                        underrun,
	output mem_fetch_pkg::mem_addr_t    mem_addr,
	output logic                        mem_read_en,
	input  mem_fetch_pkg::mem_word_t    mem_data,
	input  logic                        mem_ack,
	output logic                        bclk,
	output logic                        lrclk,
	output logic                        sdata
);
	import mem_fetch_pkg::*;
	import audio_fmt_pkg::*;

	mem_addr_t     base;		// Sequencer to fetcher.
	logic          base_valid;
	logic          base_ack;
	logic          block_end;
	mem_word_t     chunk;		// Fetcher to unpacker.
	logic          chunk_valid;
	logic          chunk_ack;
	stereo_frame_t frame;		// Unpacker to transmitter.
	logic          frame_valid;
	logic          frame_take;

	playback_sequencer u_seq (.clock, .reset_l, .start, .start_base, .block_count,
		.base, .base_valid, .base_ack, .block_end, .busy, .done);

	sample_fetcher u_fetch (.clock, .reset_l, .mem_data, .mem_ack, .mem_addr,
		.mem_read_en, .chunk, .chunk_valid, .chunk_ack, .base, .base_valid,
		.base_ack, .block_end);

	frame_unpacker u_unpack (.clock, .reset_l, .chunk, .chunk_valid, .chunk_ack,
		.frame, .frame_valid, .frame_take);

	i2s_transmitter u_i2s (.clock, .reset_l, .frame, .frame_valid, .frame_take,
		.busy, .bclk, .lrclk, .sdata, .underrun);

endmodule

`default_nettype wire

// ==== i2s_transmitter.sv ====
// I2S master transmitter. bclk runs freely from reset, and a new frame can only start on a bclk falling edge.
`timescale 1ns/1ps
`default_nettype none

module i2s_transmitter (
	input  logic                         clock,
	input  logic                         reset_l,
	input  audio_fmt_pkg::stereo_frame_t frame,
	input  logic                         frame_valid,
	output logic                         frame_take,
	input  logic                         busy,
	output logic                         bclk,
	output logic                         lrclk,
	output logic                         sdata,
	output logic                         underrun
);
	import audio_fmt_pkg::*;

	logic [BCLK_DIV_W-1:0] div_cnt;		// Half period divider.
	logic                  half_tick;	// bclk toggles this cycle.
	logic                  fall_tick;	// bclk falls this cycle.
	logic                  frame_end;	// Boundary, or nothing in flight.
	logic [BIT_CNT_W-1:0]  bit_cnt;		// Bit slot within the frame.
	logic [FRAME_BITS-1:0] shift_reg;	// Outgoing bits, MSB first.
	i2s_state_t            state;

	always_comb begin
		half_tick  = (div_cnt == BCLK_DIV_W'(BCLK_HALF - 1));
		fall_tick  = half_tick & bclk;
		frame_end  = (state == i2s_idle) | (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
		frame_take = fall_tick & frame_end & frame_valid;	// Load a new frame.
	end

	//////////////////////////////////////////////////////////////////////
	// Bit clock, word select and data.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			div_cnt  <= '0;
			bclk     <= 1'b0;
			lrclk    <= 1'b1;
			sdata    <= 1'b0;
			bit_cnt  <= '0;
			state    <= i2s_idle;
			underrun <= 1'b0;
		end else begin
			underrun <= 1'b0;
			div_cnt  <= half_tick ? '0 : div_cnt + 1'b1;
			if (half_tick)
				bclk <= ~bclk;
			if (fall_tick) begin
				// One slot late. The boundary slot carries the last LSB.
				sdata <= (state == i2s_shift) & shift_reg[FRAME_BITS-1];
				if (!frame_end) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_CNT_W'(FRAME_BITS / 2 - 1))
						lrclk <= 1'b1;		// Right channel.
				end else if (frame_valid) begin
					bit_cnt <= '0;
					lrclk   <= 1'b0;		// Left channel.
					state   <= i2s_shift;
				end else begin
					state    <= i2s_idle;
					underrun <= (state == i2s_shift) & busy;	// Data late.
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (frame_take)
			shift_reg <= frame;
		else if (fall_tick)
			shift_reg <= shift_reg << 1;
	end

endmodule

`default_nettype wire

// ==== frame_unpacker.sv ====
// Word to frame splitter. The low 32 bits of a word play first, then the high 32 bits.
`timescale 1ns/1ps
`default_nettype none

module frame_unpacker (
	input  logic                         clock,
	input  logic                         reset_l,
	input  mem_fetch_pkg::mem_word_t     chunk,
	input  logic                         chunk_valid,
	output logic                         chunk_ack,
	output audio_fmt_pkg::stereo_frame_t frame,
	output logic                         frame_valid,
	input  logic                         frame_take
);
	import audio_fmt_pkg::*;

	logic half_sel;		// High while the upper half is on offer.
	logic take_ok;		// Take of a frame that is really there.

	//////////////////////////////////////////////////////////////////////
	// Half select.
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		take_ok     = frame_take & chunk_valid;
		frame_valid = chunk_valid;			// Each word gives two frames.
		chunk_ack   = take_ok & half_sel;		// Word used up.

		if (half_sel)
			frame = stereo_frame_t'(chunk[63:32]);	// Second frame.
		else
			frame = stereo_frame_t'(chunk[31:0]);	// First frame.
	end

	// Toggles on every take, so it is back at the low half
	// when the fetcher presents its next word.
	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l)
			half_sel <= 1'b0;
		else if (take_ok)
			half_sel <= ~half_sel;
	end

endmodule

`default_nettype wire

// ==== sample_fetcher.sv ====
// Block fetcher. One read outstanding at a time, and mem_ack is valid only for the cycle that holds the data.
`timescale 1ns/1ps
`default_nettype none

module sample_fetcher (
	input  logic                     clock,
	input  logic                     reset_l,
	input  mem_fetch_pkg::mem_word_t mem_data,
	input  logic                     mem_ack,
	output mem_fetch_pkg::mem_addr_t mem_addr,
	output logic                     mem_read_en,
	output mem_fetch_pkg::mem_word_t chunk,
	output logic                     chunk_valid,
	input  logic                     chunk_ack,
	input  mem_fetch_pkg::mem_addr_t base,
	input  logic                     base_valid,
	output logic                     base_ack,
	output logic                     block_end
);
	import mem_fetch_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Block state.
	//////////////////////////////////////////////////////////////////////

	mem_addr_t     addr;		// Base of the block being read.
	logic          addr_valid;	// A block is held.
	block_offset_t offset;		// Next word to read.
	fetch_state_t  state;		// Read machine.
	logic          word_done;	// Data returned for the outstanding read.

	//////////////////////////////////////////////////////////////////////
	// Strobes and address.
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		base_ack    = base_valid & ~addr_valid;		// Take a base whenever empty.
		mem_read_en = (state == fetch_idle) & addr_valid & ~chunk_valid;	// Back-pressure.
		word_done   = (state == fetch_read_wait) & mem_ack;
		block_end   = word_done & (offset == block_offset_t'(WORDS_PER_BLOCK - 1));
		mem_addr    = addr + mem_addr_t'(offset);
	end

	//////////////////////////////////////////////////////////////////////
	// Control registers.
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			state       <= fetch_idle;
			addr_valid  <= 1'b0;
			offset      <= '0;
			chunk_valid <= 1'b0;
		end else begin
			unique case (state)
				fetch_idle: begin
					if (mem_read_en)
						state <= fetch_read_wait;
				end
				fetch_read_wait: begin
					if (mem_ack)
						state <= fetch_idle;
				end
			endcase

			if (base_ack)
				addr_valid <= 1'b1;
			else if (block_end)
				addr_valid <= 1'b0;		// Block released on its last word.

			if (word_done)
				offset <= offset + 1'b1;	// Wraps to zero after word 63.

			// Held until the unpacker has used both halves.
			if (word_done)
				chunk_valid <= 1'b1;
			else if (chunk_ack)
				chunk_valid <= 1'b0;
		end
	end

	// Payload registers.
	always_ff @(posedge clock) begin
		if (base_ack)
			addr <= base;
		if (word_done)
			chunk <= mem_data;		// Captured in the single ack cycle.
	end

endmodule

`default_nettype wire

// ==== playback_sequencer.sv ====
// Block sequencer. A start with a block count of zero is ignored, as is any start while busy.
`timescale 1ns/1ps
`default_nettype none

module playback_sequencer (
	input  logic                       clock,
	input  logic                       reset_l,
	input  logic                       start,
	input  mem_fetch_pkg::mem_addr_t   start_base,
	input  mem_fetch_pkg::block_count_t block_count,
	output mem_fetch_pkg::mem_addr_t   base,
	output logic                       base_valid,
	input  logic                       base_ack,
	input  logic                       block_end,
	output logic                       busy,
	output logic                       done
);
	import mem_fetch_pkg::*;

	block_count_t offer_left;	// Bases not yet taken by the fetcher.
	block_count_t end_left;		// Blocks not yet fully read.
	logic         accept;		// Start request taken.
	logic         base_take;	// Fetcher took the current base.

	always_comb begin
		accept    = start & ~busy & (block_count != '0);
		base_take = base_valid & base_ack;
	end

	always_ff @(posedge clock, negedge reset_l) begin
		if (!reset_l) begin
			base_valid <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			offer_left <= '0;
			end_left   <= '0;
		end else begin
			done <= 1'b0;				// Single cycle pulse.
			if (accept) begin
				busy       <= 1'b1;
				base_valid <= 1'b1;		// First base offered next cycle.
				offer_left <= block_count;
				end_left   <= block_count;
			end else begin
				if (base_take) begin
					offer_left <= offer_left - 1'b1;
					if (offer_left == block_count_t'(1))
						base_valid <= 1'b0;	// Last base handed over.
				end
				if (block_end && busy) begin
					end_left <= end_left - 1'b1;
					if (end_left == block_count_t'(1)) begin
						busy <= 1'b0;		// Falls together with done.
						done <= 1'b1;
					end
				end
			end
		end
	end

	// Next base is ready while the fetcher still reads the current block.
	always_ff @(posedge clock) begin
		if (accept)
			base <= start_base;
		else if (base_take)
			base <= base + mem_addr_t'(WORDS_PER_BLOCK);
	end

endmodule

`default_nettype wire

// ==== audio_fmt_pkg.sv ====
// Audio format types. Only 16-bit signed stereo is carried, and the bit clock is a fixed system clock divide.
`default_nettype none

package audio_fmt_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sample and frame layout.
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [15:0] sample_t;	// One PCM sample.

	// Left sits in the upper half of a frame.
	typedef struct packed {
		sample_t left;		// Bits 31:16.
		sample_t right;		// Bits 15:0.
	} stereo_frame_t;

	//////////////////////////////////////////////////////////////////////
	// Serial timing.
	//////////////////////////////////////////////////////////////////////

	localparam int BCLK_HALF  = 2;				// System clocks per bclk half period.
	localparam int FRAME_BITS = 32;				// Bit clocks per stereo frame.
	localparam int BCLK_DIV_W = $clog2(BCLK_HALF);		// Divider counter width.
	localparam int BIT_CNT_W  = $clog2(FRAME_BITS);		// Bit counter width.

	typedef enum logic {
		i2s_idle,		// Line quiet, waiting for a frame.
		i2s_shift		// Frame in progress.
	} i2s_state_t;

endpackage

`default_nettype wire

// ==== mem_fetch_pkg.sv ====
// Memory side types. Addresses count 64-bit words, and a block is fixed at 64 words (512 bytes).
`default_nettype none

package mem_fetch_pkg;

	//////////////////////////////////////////////////////////////////////
	// DRAM word interface.
	//////////////////////////////////////////////////////////////////////

	typedef logic [28:0] mem_addr_t;	// Word address, 8-byte units.
	typedef logic [63:0] mem_word_t;	// One chunk, four 16-bit samples.

	//////////////////////////////////////////////////////////////////////
	// Block geometry.
	//////////////////////////////////////////////////////////////////////

	localparam int WORDS_PER_BLOCK = 64;	// 512 bytes per block.

	typedef logic [5:0] block_offset_t;	// Word index inside a block, wraps at 64.
	typedef logic [7:0] block_count_t;	// Blocks per playback, zero means none.

	// Fetcher read machine.
	typedef enum logic {
		fetch_idle,		// Free to issue a read.
		fetch_read_wait		// One read outstanding, waiting on ack.
	} fetch_state_t;

endpackage

`default_nettype wire
